// File: logic/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

	// client side
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	// address fields
	typedef logic [`LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`SET_BITS-1:0] set_idx_t;
	typedef logic [$clog2(`LINE_WORDS)-1:0] word_sel_t;

	// word 0 in the low bits
	typedef logic [`LINE_WORDS*`WORD_W-1:0] line_t;

	typedef logic [0:0] way_t;

	// controller states
	typedef enum logic [1:0] {
		s_lookup,
		s_writeback,
		s_fetch
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// data path widths
`define WORD_W 16
`define ADDR_W 16

// line geometry
`define LINE_WORDS 4
`define SET_BITS 5
`define NUM_SETS (1 << `SET_BITS)

// address split, tag on top of set on top of word select
`define TAG_W 9
`define LINE_ADDR_W 14

// backing memory access time in cycles
`define MEM_LATENCY 4

`endif

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import cache_pkg::*; (
	input wire clk,
	input wire rst,

	// client
	input wire addr_t i_addr,
	input wire i_re,
	input wire i_we,
	input wire word_t i_wdata,
	output word_t o_rdata,
	output logic o_hit,

	// way store
	output set_idx_t o_set,
	output tag_t o_lookup_tag,
	output logic o_st_we,
	output way_t o_st_way,
	output logic o_st_valid,
	output logic o_st_dirty,
	output tag_t o_st_tag,
	output line_t o_st_line,
	input wire i_hit,
	input wire way_t i_hit_way,
	input wire i_valid0,
	input wire i_valid1,
	input wire i_dirty0,
	input wire i_dirty1,
	input wire tag_t i_tag0,
	input wire tag_t i_tag1,
	input wire line_t i_line0,
	input wire line_t i_line1,

	// lru
	output logic o_lru_we,
	output way_t o_lru_way,
	input wire way_t i_mru_way,

	// main memory
	output logic o_mem_req,
	output logic o_mem_we,
	output line_addr_t o_mem_addr,
	output line_t o_mem_wline,
	input wire i_mem_done,
	input wire line_t i_mem_rline
);

	localparam int WW = $bits(word_t);
	localparam int SEL_W = $bits(word_sel_t);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	way_t victim_q;
	way_t victim_d;

	logic req;
	tag_t req_tag;
	set_idx_t req_set;
	word_sel_t req_word;
	line_addr_t req_line_addr;

	line_t hit_line;
	line_t merged_line;

	way_t victim_new;
	way_t victim_way;
	logic victim_dirty;
	tag_t victim_tag;
	line_t victim_line;

	//////////////////////////////////////////////////////////////////////
	// address split and word path
	//////////////////////////////////////////////////////////////////////

	assign req = i_re || i_we;
	assign req_tag = i_addr[$bits(addr_t)-1 -: $bits(tag_t)];
	assign req_set = i_addr[SEL_W +: $bits(set_idx_t)];
	assign req_word = i_addr[SEL_W-1:0];
	assign req_line_addr = i_addr[$bits(addr_t)-1 -: $bits(line_addr_t)];

	assign o_set = req_set;
	assign o_lookup_tag = req_tag;

	assign hit_line = (i_hit_way == way_t'(1)) ? i_line1 : i_line0;
	assign o_rdata = hit_line[req_word*WW +: WW];

	// write data dropped into the addressed word
	always_comb begin
		merged_line = hit_line;
		merged_line[req_word*WW +: WW] = i_wdata;
	end

	// stall level, high when idle or on a hit
	assign o_hit = (state_q == s_lookup) && (i_hit || !req);

	//////////////////////////////////////////////////////////////////////
	// victim choice
	//////////////////////////////////////////////////////////////////////

	// empty way first, else least recent
	assign victim_new = !i_valid0 ? way_t'(0) :
		!i_valid1 ? way_t'(1) : ~i_mru_way;
	assign victim_way = (state_q == s_lookup) ? victim_new : victim_q;

	assign victim_dirty = (victim_way == way_t'(1)) ? (i_valid1 && i_dirty1) :
		(i_valid0 && i_dirty0);
	assign victim_tag = (victim_way == way_t'(1)) ? i_tag1 : i_tag0;
	assign victim_line = (victim_way == way_t'(1)) ? i_line1 : i_line0;

	//////////////////////////////////////////////////////////////////////
	// miss FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= s_lookup;
			victim_q <= '0;
		end else begin
			state_q <= state_d;
			victim_q <= victim_d;
		end
	end

	always_comb begin
		state_d = state_q;
		victim_d = victim_q;
		// default store write is the write-hit merge
		o_st_we = 1'b0;
		o_st_way = i_hit_way;
		o_st_valid = 1'b1;
		o_st_dirty = 1'b1;
		o_st_tag = req_tag;
		o_st_line = merged_line;
		o_lru_we = 1'b0;
		o_lru_way = i_hit_way;
		o_mem_req = 1'b0;
		o_mem_we = 1'b0;
		o_mem_addr = req_line_addr;
		o_mem_wline = victim_line;

		case (state_q)
			s_lookup: begin
				if (req && i_hit) begin
					o_lru_we = 1'b1;
					o_st_we = i_we;
				end else if (req) begin
					victim_d = victim_new;
					state_d = victim_dirty ? s_writeback : s_fetch;
				end
			end
			s_writeback: begin
				// victim line back to its own address
				o_mem_req = 1'b1;
				o_mem_we = 1'b1;
				o_mem_addr = {victim_tag, req_set};
				if (i_mem_done) begin
					state_d = s_fetch;
				end
			end
			s_fetch: begin
				o_mem_req = 1'b1;
				if (i_mem_done) begin
					// fill clean, the retry then hits
					o_st_we = 1'b1;
					o_st_way = victim_q;
					o_st_dirty = 1'b0;
					o_st_line = i_mem_rline;
					state_d = s_lookup;
				end
			end
			default: begin
				state_d = s_lookup;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_lru import cache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire set_idx_t i_set,
	input wire i_we,
	input wire way_t i_way,
	output way_t o_mru_way
);

	localparam int N_SETS = `NUM_SETS;

	// one bit per set, the way touched last
	logic [N_SETS-1:0] mru_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			mru_q <= '0;
		end else if (i_we) begin
			mru_q[i_set] <= i_way;
		end
	end

	// victim is the other way
	assign o_mru_way = mru_q[i_set];

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import cache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire addr_t i_addr,
	input wire i_re,
	input wire i_we,
	input wire word_t i_wdata,
	output word_t o_rdata,
	output logic o_hit
);

	// controller to store
	set_idx_t set;
	tag_t lookup_tag;
	logic st_we;
	way_t st_way;
	logic st_valid;
	logic st_dirty;
	tag_t st_tag;
	line_t st_line;

	// store to controller
	logic hit;
	way_t hit_way;
	logic valid0;
	logic valid1;
	logic dirty0;
	logic dirty1;
	tag_t tag0;
	tag_t tag1;
	line_t line0;
	line_t line1;

	// lru
	logic lru_we;
	way_t lru_way;
	way_t mru_way;

	// memory
	logic mem_req;
	logic mem_we;
	line_addr_t mem_addr;
	line_t mem_wline;
	logic mem_done;
	line_t mem_rline;

	dcache_way_store u_store (
		.clk(clk), .rst(rst), .i_set(set), .i_lookup_tag(lookup_tag),
		.i_we(st_we), .i_way(st_way), .i_valid(st_valid), .i_dirty(st_dirty),
		.i_tag(st_tag), .i_line(st_line), .o_hit(hit), .o_hit_way(hit_way),
		.o_valid0(valid0), .o_valid1(valid1), .o_dirty0(dirty0), .o_dirty1(dirty1),
		.o_tag0(tag0), .o_tag1(tag1), .o_line0(line0), .o_line1(line1)
	);

	dcache_lru u_lru (
		.clk(clk), .rst(rst), .i_set(set), .i_we(lru_we), .i_way(lru_way),
		.o_mru_way(mru_way)
	);

	dcache_ctrl u_ctrl (
		.clk(clk), .rst(rst), .i_addr(i_addr), .i_re(i_re), .i_we(i_we),
		.i_wdata(i_wdata), .o_rdata(o_rdata), .o_hit(o_hit),
		.o_set(set), .o_lookup_tag(lookup_tag), .o_st_we(st_we), .o_st_way(st_way),
		.o_st_valid(st_valid), .o_st_dirty(st_dirty), .o_st_tag(st_tag),
		.o_st_line(st_line), .i_hit(hit), .i_hit_way(hit_way),
		.i_valid0(valid0), .i_valid1(valid1), .i_dirty0(dirty0), .i_dirty1(dirty1),
		.i_tag0(tag0), .i_tag1(tag1), .i_line0(line0), .i_line1(line1),
		.o_lru_we(lru_we), .o_lru_way(lru_way), .i_mru_way(mru_way),
		.o_mem_req(mem_req), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
		.o_mem_wline(mem_wline), .i_mem_done(mem_done), .i_mem_rline(mem_rline)
	);

	main_mem u_mem (
		.clk(clk), .rst(rst), .i_req(mem_req), .i_we(mem_we), .i_addr(mem_addr),
		.i_wline(mem_wline), .o_done(mem_done), .o_rline(mem_rline)
	);

endmodule

`default_nettype wire

// File: logic/dcache_way_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_way_store import cache_pkg::*; (
	input wire clk,
	input wire rst,

	// lookup
	input wire set_idx_t i_set,
	input wire tag_t i_lookup_tag,

	// single write port
	input wire i_we,
	input wire way_t i_way,
	input wire i_valid,
	input wire i_dirty,
	input wire tag_t i_tag,
	input wire line_t i_line,

	output logic o_hit,
	output way_t o_hit_way,
	output logic o_valid0,
	output logic o_valid1,
	output logic o_dirty0,
	output logic o_dirty1,
	output tag_t o_tag0,
	output tag_t o_tag1,
	output line_t o_line0,
	output line_t o_line1
);

	localparam int N_SETS = `NUM_SETS;

	logic [1:0][N_SETS-1:0] valid_q;
	logic [1:0][N_SETS-1:0] dirty_q;
	tag_t tag_q [2][N_SETS];
	line_t line_q [2][N_SETS];

	logic match0;
	logic match1;

	// only valid bits are cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (i_we) begin
			valid_q[i_way][i_set] <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_we) begin
			dirty_q[i_way][i_set] <= i_dirty;
			tag_q[i_way][i_set] <= i_tag;
			line_q[i_way][i_set] <= i_line;
		end
	end

	// combinational read of both ways
	assign o_valid0 = valid_q[0][i_set];
	assign o_valid1 = valid_q[1][i_set];
	assign o_dirty0 = dirty_q[0][i_set];
	assign o_dirty1 = dirty_q[1][i_set];
	assign o_tag0 = tag_q[0][i_set];
	assign o_tag1 = tag_q[1][i_set];
	assign o_line0 = line_q[0][i_set];
	assign o_line1 = line_q[1][i_set];

	// tag compare, way 0 wins a double match
	assign match0 = o_valid0 && (o_tag0 == i_lookup_tag);
	assign match1 = o_valid1 && (o_tag1 == i_lookup_tag);
	assign o_hit = match0 || match1;
	assign o_hit_way = match0 ? way_t'(0) : way_t'(1);

endmodule

`default_nettype wire

// File: logic/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module main_mem import cache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire i_req,
	input wire i_we,
	input wire line_addr_t i_addr,
	input wire line_t i_wline,
	output logic o_done,
	output line_t o_rline
);

	localparam int N_LINES = 1 << `LINE_ADDR_W;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	// starts out all zero
	line_t mem_q [N_LINES] = '{default: '0};

	logic [CNT_W-1:0] cnt_q;
	logic last_cycle;

	//////////////////////////////////////////////////////////////////////
	// latency counter
	//////////////////////////////////////////////////////////////////////

	assign last_cycle = (cnt_q == CNT_W'(`MEM_LATENCY - 1));
	assign o_done = i_req && last_cycle;

	// restarts after each done so back to back accesses each take full latency
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (i_req && !last_cycle) begin
			cnt_q <= cnt_q + 1'b1;
		end else begin
			cnt_q <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (o_done && i_we) begin
			mem_q[i_addr] <= i_wline;
		end
	end

	// read data sampled by the controller in the done cycle
	assign o_rline = mem_q[i_addr];

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
+incdir+tests
logic/cache_pkg.sv
logic/dcache_way_store.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/main_mem.sv
logic/dcache_top.sv
tests/tb_dcache.sv

// File: tests/tb_dcache_model.svh
`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

// shadow copy of every client word, what a read must return
word_t shadow_mem [65536];

// random stream state
logic [31:0] lcg_state = 32'd60303;

task automatic clear_shadow();
	for (int a = 0; a < 65536; a++) begin
		shadow_mem[a] = '0;
	end
endtask

function automatic logic [31:0] next_random(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic word_t expected_word(input addr_t a);
	return shadow_mem[a];
endfunction

task automatic record_write(input addr_t a, input word_t d);
	shadow_mem[a] = d;
endtask

// 64 lines, four tags over sets 0 to 15
function automatic addr_t pick_window_addr(input logic [31:0] r);
	logic [5:0] line;
	logic [1:0] word;
	line = r[21:16];
	word = r[23:22];
	return {1'b1, 6'b0, line[5:4], 1'b0, line[3:0], word};
endfunction

`endif

// File: tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_dcache import cache_pkg::*;;

	logic clk = 1'b0;
	logic rst;
	addr_t addr;
	logic re;
	logic we;
	word_t wdata;
	word_t rdata;
	logic hit;

	int checks = 0;
	int errors = 0;
	logic hung = 1'b0;

	`include "tb_dcache_model.svh"

	dcache_top dut0 (
		.clk(clk), .rst(rst), .i_addr(addr), .i_re(re), .i_we(we),
		.i_wdata(wdata), .o_rdata(rdata), .o_hit(hit)
	);

	always #4 clk = ~clk;

	// idle cache never stalls
	no_req_hit: assert property (@(posedge clk) disable iff (rst) (!re && !we) |-> hit)
		else begin
			errors++;
			$display("FAILED at %0t: o_hit expected 1, got 0 with no request", $time);
		end

	task automatic check_value(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// one client access, held until o_hit
	////////////////////////////////////////////////////////////////////

	task automatic run_access(input addr_t a, input logic write, input word_t d,
		output int stall);
		int waited;
		waited = 0;
		stall = 0;
		if (!hung) begin
			@(posedge clk);
			addr <= a;
			re <= !write;
			we <= write;
			wdata <= d;
			@(negedge clk);
			while (!hit && waited < 50) begin
				waited++;
				@(negedge clk);
			end
			if (!hit) begin
				hung = 1'b1;
				errors++;
				$display("timeout: access to address %h never completed in 50 cycles", a);
			end else if (write) begin
				record_write(a, d);
				stall = waited;
			end else begin
				// value here is what the completing edge sees
				check_value($sformatf("o_rdata @%h", a), expected_word(a), rdata);
				stall = waited;
			end
			@(posedge clk);
			re <= 1'b0;
			we <= 1'b0;
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_start);
		$display("test %0d, %s: %0d errors", num, name, errors - err_start);
	endtask

	initial begin
		int stall;
		int err_start;
		logic [31:0] r;
		rst = 1'b1;
		addr = '0;
		re = 1'b0;
		we = 1'b0;
		wdata = '0;
		clear_shadow();
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		err_start = errors;
		@(negedge clk);
		check_value("o_hit", 32'd1, hit);
		run_access(16'h1234, 1'b0, '0, stall);
		run_access(16'hffff, 1'b0, '0, stall);
		run_access(16'h0777, 1'b0, '0, stall);
		finish_test(1, "reset state and cold reads", err_start);

		// write allocate into set 0
		err_start = errors;
		run_access(16'h0202, 1'b1, 16'ha5c3, stall);
		check_value("clean miss stall cycles", `MEM_LATENCY + 1, stall);
		run_access(16'h0202, 1'b0, '0, stall);
		check_value("read hit stall cycles", 32'd0, stall);
		run_access(16'h0200, 1'b0, '0, stall);
		run_access(16'h0201, 1'b0, '0, stall);
		run_access(16'h0203, 1'b0, '0, stall);
		finish_test(2, "write allocate", err_start);

		// three tags in set 5, the third evicts a dirty line
		err_start = errors;
		run_access(16'h0014, 1'b1, 16'h1111, stall);
		run_access(16'h0094, 1'b1, 16'h2222, stall);
		run_access(16'h0114, 1'b1, 16'h3333, stall);
		check_value("dirty miss stall cycles", 2 * `MEM_LATENCY + 1, stall);
		run_access(16'h0014, 1'b0, '0, stall);
		run_access(16'h0094, 1'b0, '0, stall);
		run_access(16'h0114, 1'b0, '0, stall);
		finish_test(3, "dirty eviction and refetch", err_start);

		// set 9, B becomes least recent before C arrives
		err_start = errors;
		run_access(16'h0024, 1'b0, '0, stall);
		run_access(16'h00a4, 1'b0, '0, stall);
		run_access(16'h0024, 1'b0, '0, stall);
		run_access(16'h0124, 1'b0, '0, stall);
		run_access(16'h0024, 1'b0, '0, stall);
		check_value("o_hit first cycle, line A", 32'd1, stall == 0);
		run_access(16'h00a4, 1'b0, '0, stall);
		check_value("o_hit first cycle, line B", 32'd0, stall == 0);
		finish_test(4, "LRU victim choice", err_start);

		err_start = errors;
		for (int i = 0; i < 400; i++) begin
			lcg_state = next_random(lcg_state);
			r = lcg_state;
			run_access(pick_window_addr(r), r[31], r[15:0], stall);
		end
		finish_test(5, "random window traffic", err_start);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
